//--- logic/msr_params.svh
/*
 * MSR access path parameters
 * Data widths, bank numbers, one-hot offset positions and the
 * constant values seen by read MSR
 */
`ifndef MSR_PARAMS_SVH
`define MSR_PARAMS_SVH

// Data path widths
`define MSR_DW        32
`define MSR_PSR_DW    10
`define MSR_PC_W      30
`define MSR_BANK_AW   4
`define MSR_OFF_AW    8
`define MSR_ADDR_W    (`MSR_BANK_AW + `MSR_OFF_AW)

// Bank numbers, taken from address bits 11..8
`define MSR_BANK_PS   4'd0
`define MSR_BANK_IRQC 4'd6
`define MSR_BANK_TSC  4'd7

// PS bank, bit positions in the one-hot offset
`define MSR_PS_PSR    0
`define MSR_PS_CPUID  1
`define MSR_PS_EPSR   2
`define MSR_PS_EPC    3
`define MSR_PS_COREID 4

// Interrupt controller bank
`define MSR_IRQC_IMR  0
`define MSR_IRQC_IRR  1

// Timestamp bank
`define MSR_TSC_TSR   0
`define MSR_TSC_TCR   1

// Kernel mode only after reset
`define MSR_PSR_RESET  10'h010
`define MSR_CPUID_VAL  32'h0001_0032
`define MSR_COREID_VAL 32'h0000_0001

`endif

//--- logic/msr_pkg.sv
/*
 * MSR types
 * Operation encoding, PSR field layout and the write operand union
 * that is decoded both as a raw word and as PSR fields
 */
`include "msr_params.svh"

package msr_pkg;

   // Operation carried with a committed instruction
   typedef enum logic [1:0] {
      op_none = 2'd0,
      op_rmsr = 2'd1,
      op_wmsr = 2'd2
   } msr_op_e;

   // Processor status register, msb first
   typedef struct packed {
      logic [1:0] res_hi;   // bits 9..8
      logic       dmme;     // data MMU enable
      logic       imme;     // instruction MMU enable
      logic       ire;      // interrupt enable
      logic       rm;       // kernel mode
      logic [2:0] res_lo;   // bits 3..1
      logic       cc;       // condition flag
   } psr_t;

   // PSR image in the low bits of a data word
   typedef struct packed {
      logic [`MSR_DW-`MSR_PSR_DW-1:0] pad;
      psr_t                           psr;
   } psr_word_t;

   // Write operand, raw or as PSR fields
   typedef union packed {
      logic [`MSR_DW-1:0] raw;
      psr_word_t          f;
   } msr_word_u;

endpackage

//--- logic/msr_addr_stage.sv
/*
 * MSR stage 1
 * Registers a committed instruction, forms the MSR address from the
 * two address operands and splits it into bank and one-hot offset
 */
`timescale 1ns/1ps
`include "msr_params.svh"

module msr_addr_stage (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    commit,
   input  msr_pkg::msr_op_e        op,
   input  logic [`MSR_DW-1:0]      operand_1,
   input  logic [`MSR_DW-1:0]      operand_2,
   input  logic [`MSR_DW-1:0]      operand_3,
   input  logic                    syscall,
   input  logic                    ext_exc,
   input  logic                    eret,
   input  logic                    cc_we,
   input  logic                    cc_nxt,
   input  logic [`MSR_PC_W-1:0]    insn_pc,
   input  logic [`MSR_DW-1:0]      link_addr,
   output logic                    s1_commit,
   output msr_pkg::msr_op_e        s1_op,
   output logic [`MSR_BANK_AW-1:0] s1_bank,
   output logic [`MSR_OFF_AW-1:0]  s1_off,
   output logic [`MSR_DW-1:0]      s1_wdata,
   output logic                    s1_syscall,
   output logic                    s1_ext_exc,
   output logic                    s1_eret,
   output logic                    s1_cc_we,
   output logic                    s1_cc_nxt,
   output logic [`MSR_PC_W-1:0]    s1_insn_pc,
   output logic [`MSR_DW-1:0]      s1_link_addr
);

   // Only the low 12 bits of the sum select a register
   logic [`MSR_ADDR_W-1:0] msr_addr;

   assign msr_addr = operand_1[`MSR_ADDR_W-1:0] + operand_2[`MSR_ADDR_W-1:0];

   // Control state, every event is qualified by commit
   always_ff @(posedge clk) begin
      if (reset) begin
         s1_commit  <= 1'b0;
         s1_op      <= msr_pkg::op_none;
         s1_syscall <= 1'b0;
         s1_ext_exc <= 1'b0;
         s1_eret    <= 1'b0;
         s1_cc_we   <= 1'b0;
      end else begin
         s1_commit  <= commit;
         s1_op      <= commit ? op : msr_pkg::op_none;
         s1_syscall <= commit & syscall;
         s1_ext_exc <= commit & ext_exc;
         s1_eret    <= commit & eret;
         s1_cc_we   <= commit & cc_we;
      end
   end

   // Payload, loaded only with an instruction
   always_ff @(posedge clk) begin
      if (commit) begin
         s1_bank      <= msr_addr[`MSR_ADDR_W-1:`MSR_OFF_AW];
         s1_off       <= msr_addr[`MSR_OFF_AW-1:0];
         s1_wdata     <= operand_3;
         s1_cc_nxt    <= cc_nxt;
         s1_insn_pc   <= insn_pc;
         s1_link_addr <= link_addr;
      end
   end

endmodule

//--- logic/msr_exec_unit.sv
/*
 * MSR stage 2
 * Read multiplexer, write-back values and enables for the MSRs,
 * exception entry and return, condition flag update
 */
`timescale 1ns/1ps
`include "msr_params.svh"

module msr_exec_unit (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    s1_commit,
   input  msr_pkg::msr_op_e        s1_op,
   input  logic [`MSR_BANK_AW-1:0] s1_bank,
   input  logic [`MSR_OFF_AW-1:0]  s1_off,
   input  logic [`MSR_DW-1:0]      s1_wdata,
   input  logic                    s1_syscall,
   input  logic                    s1_ext_exc,
   input  logic                    s1_eret,
   input  logic                    s1_cc_we,
   input  logic                    s1_cc_nxt,
   input  logic [`MSR_PC_W-1:0]    s1_insn_pc,
   input  logic [`MSR_DW-1:0]      s1_link_addr,
   input  logic [`MSR_PSR_DW-1:0]  psr,
   input  logic [`MSR_PSR_DW-1:0]  epsr,
   input  logic [`MSR_DW-1:0]      epc,
   input  logic [`MSR_DW-1:0]      imr,
   input  logic [`MSR_DW-1:0]      irr,
   input  logic [`MSR_DW-1:0]      tsr,
   input  logic [`MSR_DW-1:0]      tcr,
   output logic [`MSR_PSR_DW-1:0]  psr_nxt,
   output logic                    psr_we,
   output logic [`MSR_PSR_DW-1:0]  epsr_nxt,
   output logic                    epsr_we,
   output logic [`MSR_DW-1:0]      epc_nxt,
   output logic                    epc_we,
   output logic [`MSR_DW-1:0]      imr_nxt,
   output logic                    imr_we,
   output logic [`MSR_DW-1:0]      tsr_nxt,
   output logic                    tsr_we,
   output logic [`MSR_DW-1:0]      tcr_nxt,
   output logic                    tcr_we,
   output logic                    exp_entry,
   output logic                    rd_valid,
   output logic [`MSR_DW-1:0]      rd_data
);

   logic bank_ps, bank_irqc, bank_tsc;
   logic is_rd, is_wr;
   logic wr_psr, wr_epsr, wr_epc;
   logic [`MSR_DW-1:0] dout_ps, dout_irqc, dout_tsc, rd_mux;
   msr_pkg::msr_word_u wop;
   msr_pkg::psr_t      psr_old, psr_clean, psr_sel;

   assign bank_ps   = (s1_bank == `MSR_BANK_PS);
   assign bank_irqc = (s1_bank == `MSR_BANK_IRQC);
   assign bank_tsc  = (s1_bank == `MSR_BANK_TSC);

   assign is_rd = s1_commit & (s1_op == msr_pkg::op_rmsr);
   assign is_wr = s1_commit & (s1_op == msr_pkg::op_wmsr);

   // Read side, one AND-OR mux per bank
   assign dout_ps =
      ({`MSR_DW{s1_off[`MSR_PS_PSR]}} & {{(`MSR_DW-`MSR_PSR_DW){1'b0}}, psr}) |
      ({`MSR_DW{s1_off[`MSR_PS_CPUID]}} & `MSR_CPUID_VAL) |
      ({`MSR_DW{s1_off[`MSR_PS_EPSR]}} & {{(`MSR_DW-`MSR_PSR_DW){1'b0}}, epsr}) |
      ({`MSR_DW{s1_off[`MSR_PS_EPC]}} & epc) |
      ({`MSR_DW{s1_off[`MSR_PS_COREID]}} & `MSR_COREID_VAL);

   assign dout_irqc =
      ({`MSR_DW{s1_off[`MSR_IRQC_IMR]}} & imr) |
      ({`MSR_DW{s1_off[`MSR_IRQC_IRR]}} & irr);

   assign dout_tsc =
      ({`MSR_DW{s1_off[`MSR_TSC_TSR]}} & tsr) |
      ({`MSR_DW{s1_off[`MSR_TSC_TCR]}} & tcr);

   // Unmapped banks fall through as zero
   assign rd_mux =
      ({`MSR_DW{bank_ps}} & dout_ps) |
      ({`MSR_DW{bank_irqc}} & dout_irqc) |
      ({`MSR_DW{bank_tsc}} & dout_tsc);

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= is_rd;
      end
   end

   always_ff @(posedge clk) begin
      if (is_rd) begin
         rd_data <= rd_mux;
      end
   end

   // Write operand seen as PSR fields, reserved bits dropped
   assign wop     = s1_wdata;
   assign psr_old = psr;

   always_comb begin
      psr_clean        = wop.f.psr;
      psr_clean.res_hi = '0;
      psr_clean.res_lo = '0;
   end

   assign wr_psr  = is_wr & bank_ps & s1_off[`MSR_PS_PSR];
   assign wr_epsr = is_wr & bank_ps & s1_off[`MSR_PS_EPSR];
   assign wr_epc  = is_wr & bank_ps & s1_off[`MSR_PS_EPC];

   assign exp_entry = s1_syscall | s1_ext_exc;

   // PSR sources, at most one is active per commit
   always_comb begin
      psr_sel = psr_clean;
      if (exp_entry) begin
         psr_sel     = psr_old;
         psr_sel.rm  = 1'b1;
         psr_sel.ire = 1'b0;
      end else if (s1_eret) begin
         psr_sel = epsr;
      end else if (s1_cc_we) begin
         psr_sel    = psr_old;
         psr_sel.cc = s1_cc_nxt;
      end
   end

   assign psr_nxt = psr_sel;
   assign psr_we  = exp_entry | s1_eret | s1_cc_we | wr_psr;

   assign epsr_nxt = wr_epsr ? psr_clean : psr_old;
   assign epsr_we  = exp_entry | wr_epsr;

   // Syscall resumes after itself, an external exception replays the insn
   assign epc_nxt = wr_epc     ? wop.raw :
                    s1_ext_exc ? {s1_insn_pc, 2'b00} : s1_link_addr;
   assign epc_we  = exp_entry | wr_epc;

   assign imr_nxt = wop.raw;
   assign imr_we  = is_wr & bank_irqc & s1_off[`MSR_IRQC_IMR];
   assign tsr_nxt = wop.raw;
   assign tsr_we  = is_wr & bank_tsc & s1_off[`MSR_TSC_TSR];
   assign tcr_nxt = wop.raw;
   assign tcr_we  = is_wr & bank_tsc & s1_off[`MSR_TSC_TCR];

   a_psr_src_mutex : assert property (@(posedge clk) disable iff (reset)
      $onehot0({exp_entry, s1_eret, s1_cc_we, wr_psr}))
      else $error("PSR write-back sources not mutually exclusive");

   a_exc_src_mutex : assert property (@(posedge clk) disable iff (reset)
      $onehot0({s1_syscall, s1_ext_exc}))
      else $error("syscall and external exception in one commit");

endmodule

//--- logic/msr_regfile.sv
/*
 * MSR register file
 * Holds PSR, EPSR, EPC, IMR, IRR, TSR and TCR, applies stage 2 writes,
 * runs the timestamp counter and samples the interrupt lines
 */
`timescale 1ns/1ps
`include "msr_params.svh"

module msr_regfile (
   input  logic                   clk,
   input  logic                   reset,
   input  logic [`MSR_DW-1:0]     irq_lines,
   input  logic [`MSR_PSR_DW-1:0] psr_nxt,
   input  logic                   psr_we,
   input  logic [`MSR_PSR_DW-1:0] epsr_nxt,
   input  logic                   epsr_we,
   input  logic [`MSR_DW-1:0]     epc_nxt,
   input  logic                   epc_we,
   input  logic [`MSR_DW-1:0]     imr_nxt,
   input  logic                   imr_we,
   input  logic [`MSR_DW-1:0]     tsr_nxt,
   input  logic                   tsr_we,
   input  logic [`MSR_DW-1:0]     tcr_nxt,
   input  logic                   tcr_we,
   output logic [`MSR_PSR_DW-1:0] psr,
   output logic [`MSR_PSR_DW-1:0] epsr,
   output logic [`MSR_DW-1:0]     epc,
   output logic [`MSR_DW-1:0]     imr,
   output logic [`MSR_DW-1:0]     irr,
   output logic [`MSR_DW-1:0]     tsr,
   output logic [`MSR_DW-1:0]     tcr
);

   msr_pkg::psr_t psr_view;

   // Status and exception registers
   always_ff @(posedge clk) begin
      if (reset) begin
         psr  <= `MSR_PSR_RESET;
         epsr <= '0;
         epc  <= '0;
      end else begin
         if (psr_we) begin
            psr <= psr_nxt;
         end
         if (epsr_we) begin
            epsr <= epsr_nxt;
         end
         if (epc_we) begin
            epc <= epc_nxt;
         end
      end
   end

   // Interrupt mask and request registers
   always_ff @(posedge clk) begin
      if (reset) begin
         imr <= '0;
         irr <= '0;
      end else begin
         if (imr_we) begin
            imr <= imr_nxt;
         end
         irr <= irq_lines;
      end
   end

   // Timestamp counter, a software write wins over counting
   always_ff @(posedge clk) begin
      if (reset) begin
         tsr <= '0;
         tcr <= '0;
      end else begin
         if (tsr_we) begin
            tsr <= tsr_nxt;
         end else if (tcr[0]) begin
            tsr <= tsr + 1'b1;
         end
         if (tcr_we) begin
            tcr <= tcr_nxt;
         end
      end
   end

   assign psr_view = psr;

   // Every PSR source in stage 2 strips the reserved bits
   a_psr_reserved_zero : assert property (@(posedge clk) disable iff (reset)
      (psr_view.res_hi == '0) && (psr_view.res_lo == '0))
      else $error("Reserved PSR bits set in stored PSR");

endmodule

//--- logic/msr_unit_top.sv
/*
 * MSR unit top level
 * Address stage, execution unit and register file of the
 * read/write MSR path
 */
`timescale 1ns/1ps
`include "msr_params.svh"

module msr_unit_top (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   commit,
   input  msr_pkg::msr_op_e       op,
   input  logic [`MSR_DW-1:0]     operand_1,
   input  logic [`MSR_DW-1:0]     operand_2,
   input  logic [`MSR_DW-1:0]     operand_3,
   input  logic                   syscall,
   input  logic                   ext_exc,
   input  logic                   eret,
   input  logic                   cc_we,
   input  logic                   cc_nxt,
   input  logic [`MSR_PC_W-1:0]   insn_pc,
   input  logic [`MSR_DW-1:0]     link_addr,
   input  logic [`MSR_DW-1:0]     irq_lines,
   output logic                   rd_valid,
   output logic [`MSR_DW-1:0]     rd_data,
   output logic [`MSR_PSR_DW-1:0] psr,
   output logic                   exp_entry
);

   // Stage 1 to stage 2
   logic                    s1_commit;
   msr_pkg::msr_op_e        s1_op;
   logic [`MSR_BANK_AW-1:0] s1_bank;
   logic [`MSR_OFF_AW-1:0]  s1_off;
   logic [`MSR_DW-1:0]      s1_wdata;
   logic                    s1_syscall, s1_ext_exc, s1_eret;
   logic                    s1_cc_we, s1_cc_nxt;
   logic [`MSR_PC_W-1:0]    s1_insn_pc;
   logic [`MSR_DW-1:0]      s1_link_addr;

   // Register file state and write-back
   logic [`MSR_PSR_DW-1:0] epsr;
   logic [`MSR_DW-1:0]     epc, imr, irr, tsr, tcr;
   logic [`MSR_PSR_DW-1:0] psr_nxt, epsr_nxt;
   logic [`MSR_DW-1:0]     epc_nxt, imr_nxt, tsr_nxt, tcr_nxt;
   logic                   psr_we, epsr_we, epc_we, imr_we, tsr_we, tcr_we;

   msr_addr_stage u_addr_stage (
      .clk, .reset, .commit, .op, .operand_1, .operand_2, .operand_3,
      .syscall, .ext_exc, .eret, .cc_we, .cc_nxt, .insn_pc, .link_addr,
      .s1_commit, .s1_op, .s1_bank, .s1_off, .s1_wdata,
      .s1_syscall, .s1_ext_exc, .s1_eret, .s1_cc_we, .s1_cc_nxt,
      .s1_insn_pc, .s1_link_addr
   );

   msr_exec_unit u_exec_unit (
      .clk, .reset,
      .s1_commit, .s1_op, .s1_bank, .s1_off, .s1_wdata,
      .s1_syscall, .s1_ext_exc, .s1_eret, .s1_cc_we, .s1_cc_nxt,
      .s1_insn_pc, .s1_link_addr,
      .psr, .epsr, .epc, .imr, .irr, .tsr, .tcr,
      .psr_nxt, .psr_we, .epsr_nxt, .epsr_we, .epc_nxt, .epc_we,
      .imr_nxt, .imr_we, .tsr_nxt, .tsr_we, .tcr_nxt, .tcr_we,
      .exp_entry, .rd_valid, .rd_data
   );

   // PSR leaves the unit straight from the register file
   msr_regfile u_regfile (
      .clk, .reset, .irq_lines,
      .psr_nxt, .psr_we, .epsr_nxt, .epsr_we, .epc_nxt, .epc_we,
      .imr_nxt, .imr_we, .tsr_nxt, .tsr_we, .tcr_nxt, .tcr_we,
      .psr, .epsr, .epc, .imr, .irr, .tsr, .tcr
   );

endmodule

//--- verification/msr_unit_tb.sv
/*
 * MSR unit testbench
 * Drives read and write MSR commits, exceptions and flag updates into
 * the MSR unit, keeps a shadow model of the registers and checks read
 * data, psr and exp_entry against it with concurrent assertions
 */
`timescale 1ns/1ps
`include "msr_params.svh"

module msr_unit_tb;

   localparam int CLK_PERIOD = 20;
   localparam int ROUNDS = 12;
   // Upper bound on commits and idle cycles over all tests
   localparam int COMMIT_BUDGET = 100 + ROUNDS * 14;
   localparam int MARGIN_NS = 1000;

   localparam logic [9:0] PSR_MASK = 10'h0f1;
   localparam int PSR_RM = 4;
   localparam int PSR_IRE = 5;

   localparam logic [11:0] A_PSR    = {`MSR_BANK_PS, 8'(1 << `MSR_PS_PSR)};
   localparam logic [11:0] A_CPUID  = {`MSR_BANK_PS, 8'(1 << `MSR_PS_CPUID)};
   localparam logic [11:0] A_EPSR   = {`MSR_BANK_PS, 8'(1 << `MSR_PS_EPSR)};
   localparam logic [11:0] A_EPC    = {`MSR_BANK_PS, 8'(1 << `MSR_PS_EPC)};
   localparam logic [11:0] A_COREID = {`MSR_BANK_PS, 8'(1 << `MSR_PS_COREID)};
   localparam logic [11:0] A_IMR    = {`MSR_BANK_IRQC, 8'(1 << `MSR_IRQC_IMR)};
   localparam logic [11:0] A_IRR    = {`MSR_BANK_IRQC, 8'(1 << `MSR_IRQC_IRR)};
   localparam logic [11:0] A_TSR    = {`MSR_BANK_TSC, 8'(1 << `MSR_TSC_TSR)};
   localparam logic [11:0] A_TCR    = {`MSR_BANK_TSC, 8'(1 << `MSR_TSC_TCR)};
   // Bank 3 is unmapped, offset bit 6 of the PS bank is unused
   localparam logic [11:0] A_HOLE   = 12'h301;
   localparam logic [11:0] A_PS_GAP = 12'h040;

   localparam logic [11:0] RW_REGS [5] = '{A_EPC, A_IMR, A_TCR, A_PSR, A_EPSR};

   logic                   clk = 1'b0;
   logic                   reset;
   logic                   commit;
   msr_pkg::msr_op_e       op;
   logic [`MSR_DW-1:0]     operand_1, operand_2, operand_3;
   logic                   syscall, ext_exc, eret;
   logic                   cc_we, cc_nxt;
   logic [`MSR_PC_W-1:0]   insn_pc;
   logic [`MSR_DW-1:0]     link_addr;
   logic [`MSR_DW-1:0]     irq_lines;
   logic                   rd_valid;
   logic [`MSR_DW-1:0]     rd_data;
   logic [`MSR_PSR_DW-1:0] psr;
   logic                   exp_entry;

   // Shadow model
   logic [9:0]  m_psr, m_epsr;
   logic [31:0] m_epc, m_imr, m_tcr, m_tsr_val;
   int          m_tsr_edge;
   int          cyc = 0;
   logic [31:0] rng_state = 32'ha581_0796;
   string       test_name;

   // Expected responses, lined up with the DUT latency
   logic        chk_vld, chk_exc;
   logic [31:0] chk_data;
   logic        rv_d1, rv_d2, exc_d1;
   logic [31:0] rd_exp_d1, rd_exp_d2;
   logic [9:0]  psr_d1, psr_d2;
   string       name_d1, name_d2;

   msr_unit_top DUT (
      .clk, .reset, .commit, .op, .operand_1, .operand_2, .operand_3,
      .syscall, .ext_exc, .eret, .cc_we, .cc_nxt, .insn_pc, .link_addr,
      .irq_lines, .rd_valid, .rd_data, .psr, .exp_entry
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (reset) begin
         rv_d1  <= 1'b0;
         rv_d2  <= 1'b0;
         exc_d1 <= 1'b0;
         psr_d1 <= `MSR_PSR_RESET;
         psr_d2 <= `MSR_PSR_RESET;
      end else begin
         rv_d1  <= chk_vld;
         rv_d2  <= rv_d1;
         exc_d1 <= chk_exc;
         psr_d1 <= m_psr;
         psr_d2 <= psr_d1;
      end
      rd_exp_d1 <= chk_data;
      rd_exp_d2 <= rd_exp_d1;
      name_d1   <= test_name;
      name_d2   <= name_d1;
   end

   task automatic report_failure(input string line);
      $display("%s", line);
      $display("Regression failed");
      $fatal(1);
   endtask

   // Outputs settle after the rising edge, so they are checked on the falling one
   a_rd_valid : assert property (@(negedge clk) disable iff (reset) rd_valid == rv_d2)
      else report_failure($sformatf("ERROR %s rd_valid expected %0b actual %0b",
                                    name_d2, rv_d2, rd_valid));

   a_rd_data : assert property (@(negedge clk) disable iff (reset)
      rd_valid |-> rd_data == rd_exp_d2)
      else report_failure($sformatf("ERROR %s rd_data expected %h actual %h",
                                    name_d2, rd_exp_d2, rd_data));

   a_psr : assert property (@(negedge clk) disable iff (reset) psr == psr_d2)
      else report_failure($sformatf("ERROR %s psr expected %h actual %h",
                                    test_name, psr_d2, psr));

   a_exp_entry : assert property (@(negedge clk) disable iff (reset) exp_entry == exc_d1)
      else report_failure($sformatf("ERROR %s exp_entry expected %0b actual %0b",
                                    test_name, exc_d1, exp_entry));

   function automatic logic [31:0] xorshift32();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   // Value a read MSR returns when sampled at the next rising edge
   function automatic logic [31:0] expect_read(input logic [11:0] a);
      logic [31:0] v;
      v = '0;
      case (a)
         A_PSR:    v = {22'b0, m_psr};
         A_CPUID:  v = `MSR_CPUID_VAL;
         A_EPSR:   v = {22'b0, m_epsr};
         A_EPC:    v = m_epc;
         A_COREID: v = `MSR_COREID_VAL;
         A_IMR:    v = m_imr;
         A_IRR:    v = irq_lines;
         A_TCR:    v = m_tcr;
         A_TSR: begin
            if (m_tcr[0]) begin
               v = m_tsr_val + 32'(cyc - m_tsr_edge);
            end else begin
               v = m_tsr_val;
            end
         end
         default:  v = '0;
      endcase
      return v;
   endfunction

   function automatic void model_write(input logic [11:0] a, input logic [31:0] d);
      case (a)
         A_PSR:  m_psr = d[9:0] & PSR_MASK;
         A_EPSR: m_epsr = d[9:0] & PSR_MASK;
         A_EPC:  m_epc = d;
         A_IMR:  m_imr = d;
         A_TCR:  m_tcr = d;
         A_TSR: begin
            m_tsr_val = d;
            m_tsr_edge = cyc + 1;
         end
         default: ;
      endcase
   endfunction

   task automatic clear_inputs();
      commit  = 1'b0;
      op      = msr_pkg::op_none;
      syscall = 1'b0;
      ext_exc = 1'b0;
      eret    = 1'b0;
      cc_we   = 1'b0;
      cc_nxt  = 1'b0;
      chk_vld = 1'b0;
      chk_exc = 1'b0;
   endtask

   // Random split of the address over the two operands
   task automatic set_addr(input logic [11:0] a);
      logic [31:0] r1, r2;
      r1 = xorshift32();
      r2 = xorshift32();
      operand_1 = r1;
      operand_2 = {r2[31:12], a - r1[11:0]};
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(negedge clk);
         clear_inputs();
      end
   endtask

   task automatic read_msr(input logic [11:0] a);
      @(negedge clk);
      clear_inputs();
      set_addr(a);
      op       = msr_pkg::op_rmsr;
      commit   = 1'b1;
      chk_vld  = 1'b1;
      chk_data = expect_read(a);
   endtask

   task automatic write_msr(input logic [11:0] a, input logic [31:0] d);
      @(negedge clk);
      clear_inputs();
      set_addr(a);
      op        = msr_pkg::op_wmsr;
      operand_3 = d;
      commit    = 1'b1;
      model_write(a, d);
   endtask

   task automatic take_exception(input logic is_ext);
      logic [31:0] r;
      @(negedge clk);
      clear_inputs();
      r         = xorshift32();
      insn_pc   = r[29:0];
      link_addr = xorshift32();
      commit    = 1'b1;
      syscall   = ~is_ext;
      ext_exc   = is_ext;
      chk_exc   = 1'b1;
      m_epsr    = m_psr;
      m_epc     = is_ext ? {r[29:0], 2'b00} : link_addr;
      m_psr[PSR_RM]  = 1'b1;
      m_psr[PSR_IRE] = 1'b0;
   endtask

   task automatic return_from_exception();
      @(negedge clk);
      clear_inputs();
      commit = 1'b1;
      eret   = 1'b1;
      m_psr  = m_epsr;
   endtask

   task automatic update_cc(input logic b);
      @(negedge clk);
      clear_inputs();
      commit   = 1'b1;
      cc_we    = 1'b1;
      cc_nxt   = b;
      m_psr[0] = b;
   endtask

   initial begin : watchdog
      #(COMMIT_BUDGET * CLK_PERIOD + MARGIN_NS);
      report_failure($sformatf("Timeout: run did not finish within %0d ns",
                               COMMIT_BUDGET * CLK_PERIOD + MARGIN_NS));
   end

   initial begin
      logic [31:0] r;
      int          k;
      reset      = 1'b1;
      operand_1  = '0;
      operand_2  = '0;
      operand_3  = '0;
      insn_pc    = '0;
      link_addr  = '0;
      irq_lines  = '0;
      chk_data   = '0;
      clear_inputs();
      m_psr      = `MSR_PSR_RESET;
      m_epsr     = '0;
      m_epc      = '0;
      m_imr      = '0;
      m_tcr      = '0;
      m_tsr_val  = '0;
      m_tsr_edge = 0;
      test_name  = "reset_values";
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      read_msr(A_PSR);
      read_msr(A_CPUID);
      read_msr(A_EPSR);
      read_msr(A_EPC);
      read_msr(A_COREID);
      read_msr(A_IMR);
      read_msr(A_IRR);
      read_msr(A_TSR);
      read_msr(A_HOLE);
      read_msr(A_PS_GAP);

      test_name = "write_read";
      irq_lines = xorshift32();
      idle(2);
      for (int i = 0; i < ROUNDS; i++) begin
         for (int j = 0; j < 5; j++) begin
            write_msr(RW_REGS[j], xorshift32());
            read_msr(RW_REGS[j]);
         end
         // Read-only registers ignore writes
         write_msr(A_CPUID, xorshift32());
         read_msr(A_CPUID);
         write_msr(A_IRR, xorshift32());
         read_msr(A_IRR);
      end

      test_name = "syscall";
      write_msr(A_PSR, xorshift32() | 32'h20);
      take_exception(1'b0);
      read_msr(A_EPC);
      read_msr(A_EPSR);
      return_from_exception();
      read_msr(A_PSR);

      test_name = "ext_exc";
      take_exception(1'b1);
      read_msr(A_EPC);
      read_msr(A_EPSR);
      return_from_exception();

      test_name = "cond_flag";
      for (int i = 0; i < 8; i++) begin
         r = xorshift32();
         update_cc(r[0]);
      end
      read_msr(A_PSR);

      test_name = "timestamp";
      write_msr(A_TCR, 32'h1);
      write_msr(A_TSR, xorshift32());
      read_msr(A_TSR);
      r = xorshift32();
      k = 1 + int'(r[2:0]);
      idle(k - 1);
      read_msr(A_TSR);
      write_msr(A_TSR, xorshift32());
      idle(2);
      read_msr(A_TSR);
      read_msr(A_TSR);

      idle(4);
      $display("Regression passed");
      $finish;
   end

endmodule

//--- all.f
+incdir+logic
logic/msr_pkg.sv
logic/msr_addr_stage.sv
logic/msr_exec_unit.sv
logic/msr_regfile.sv
logic/msr_unit_top.sv
verification/msr_unit_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = msr_unit_tb
FILELIST = all.f
BUILD    = obj_dir
PASS_MSG = Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with $(TOOL) and run the regression"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
